//--- hdl/tx_engine_defs.svh
/*
   widths and fixed field codes for the pcie tx engine
   include in every rtl or sim file that sizes a stream, counter or timestamp
*/
`ifndef TX_ENGINE_DEFS_SVH
`define TX_ENGINE_DEFS_SVH

// --------------------
// stream geometry
// --------------------
`define TX_DATA_W    256   // axis data, one beat
`define TX_KEEP_W    8     // one keep bit per dword
`define TX_BEAT_DW   8     // dwords carried per beat
`define CC_USER_W    33    // completer completion tuser
`define RQ_USER_W    60    // requester request tuser

// --------------------
// counters
// --------------------
`define TS_W         64    // free running timestamp
`define ECHO_CNT_W   14    // pending echo triggers
`define DW_CNT_W     10    // dword count of one tlp

// --------------------
// field codes
// --------------------
`define REQ_TYPE_MWR 4'd1  // memory write request

`endif

//--- hdl/pcie_desc_pkg.sv
/*
   descriptor layouts for the 256-bit pcie streams
   cc_desc_t is the 3dw completion header plus one data dword,
   rq_desc_t the requester header; both sit in the low 128 bits of a beat
*/
package pcie_desc_pkg;

   typedef logic [3:0] req_type_t;   // rq request type field

   // completer completion, dword 3 first in the packed order
   typedef struct packed {
      logic [31:0] rd_data;        // dword 3
      logic        force_ecrc;     // dword 2
      logic [2:0]  attr;
      logic [2:0]  tc;
      logic        compl_id_en;
      logic [15:0] completer_id;
      logic [7:0]  tag;
      logic [15:0] requester_id;   // dword 1
      logic        rsvd_1;
      logic        poisoned;
      logic [2:0]  status;         // 000 successful completion
      logic [10:0] dword_count;
      logic [2:0]  rsvd_0b;        // dword 0, locked read in bit 29
      logic [12:0] byte_count;
      logic [5:0]  rsvd_0a;
      logic [1:0]  addr_type;
      logic        rsvd_0;
      logic [6:0]  lower_addr;
   } cc_desc_t;

   // requester request, address in dwords 0-1
   typedef struct packed {
      logic        force_ecrc;     // dword 3
      logic [2:0]  attr;
      logic [2:0]  tc;
      logic        req_id_en;
      logic [15:0] completer_id;
      logic [7:0]  tag;
      logic [15:0] requester_id;   // dword 2
      logic        poisoned;
      req_type_t   req_type;
      logic [10:0] dword_count;
      logic [61:0] addr;           // byte address bits 63:2
      logic [1:0]  addr_type;
   } rq_desc_t;

endpackage

//--- hdl/tx_ctrl_pkg.sv
/*
   control types shared by the requester, the latency logger and the top
   sequencer state, tlp tag and log bram address
*/
package tx_ctrl_pkg;

   // --------------------
   // requester sequencer
   // --------------------
   typedef enum logic [1:0] {
      RQ_IDLE,      // waiting for start or echo credit
      RQ_PAYLOAD    // header out, payload beats pending
   } rq_state_t;

   typedef logic [7:0] tag_t;   // {tlp count, side bit}

   // --------------------
   // latency log
   // --------------------
   // 14 bits covers the largest log of 16384 entries
   typedef logic [13:0] log_addr_t;

endpackage

//--- hdl/cc_completer.sv
/*
   completer completion for one-dword reads
   sends one beat on the cc stream two cycles after req_compl_i,
   holds it until cc_tready_i and pulses compl_done_o once per completion
*/
`timescale 1ns/10ps
`include "tx_engine_defs.svh"

module cc_completer
   import pcie_desc_pkg::*;
(
   input  logic                  clk,
   input  logic                  init_rst_i,
   input  logic                  req_compl_i,   // level from rx side
   input  logic [2:0]            req_tc_i,
   input  logic [1:0]            req_attr_i,
   input  logic [9:0]            req_len_i,
   input  logic [15:0]           req_rid_i,
   input  logic [7:0]            req_tag_i,
   input  logic [3:0]            req_be_i,
   input  logic [6:0]            req_addr_i,
   input  logic [31:0]           rd_data_i,
   input  logic                  cc_tready_i,
   output logic [`TX_DATA_W-1:0] cc_tdata_o,
   output logic [`TX_KEEP_W-1:0] cc_tkeep_o,
   output logic [`CC_USER_W-1:0] cc_tuser_o,
   output logic                  cc_tlast_o,
   output logic                  cc_tvalid_o,
   output logic                  compl_done_o
);

   logic        req_compl_q;    // registered request level
   logic        cc_valid_q;     // completion waiting on the bus
   logic        compl_done_q;
   logic        load_cpl;
   logic [12:0] byte_count;
   logic [1:0]  be_idx;         // lowest enabled byte
   cc_desc_t    desc_next;
   cc_desc_t    cc_desc_q;

   // byte count from first/last enabled byte
   always_comb begin
      casez (req_be_i)
         4'b1??1:                   byte_count = 13'd4;
         4'b01?1, 4'b1?10:          byte_count = 13'd3;
         4'b0011, 4'b0110, 4'b1100: byte_count = 13'd2;
         default:                   byte_count = 13'd1;   // single byte or none
      endcase
   end

   always_comb begin
      casez (req_be_i)
         4'b???1: be_idx = 2'd0;
         4'b??10: be_idx = 2'd1;
         4'b?100: be_idx = 2'd2;
         4'b1000: be_idx = 2'd3;
         default: be_idx = 2'd0;   // no enable set
      endcase
   end

   // --------------------
   // descriptor
   // --------------------
   always_comb begin
      desc_next              = '0;            // completer id 0, status successful
      desc_next.rd_data      = rd_data_i;
      desc_next.attr         = {1'b0, req_attr_i};
      desc_next.tc           = req_tc_i;
      desc_next.tag          = req_tag_i;
      desc_next.requester_id = req_rid_i;
      desc_next.dword_count  = {1'b0, req_len_i};
      desc_next.byte_count   = byte_count;
      desc_next.lower_addr   = {req_addr_i[4:0], be_idx};
   end

   assign load_cpl = !cc_valid_q && req_compl_q && !compl_done_q;

   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         req_compl_q  <= 1'b0;
         cc_valid_q   <= 1'b0;
         compl_done_q <= 1'b0;
      end else begin
         req_compl_q  <= req_compl_i;
         compl_done_q <= load_cpl;            // one cycle pulse
         if (load_cpl) begin
            cc_valid_q <= 1'b1;
         end else if (cc_valid_q && cc_tready_i) begin
            cc_valid_q <= 1'b0;               // beat taken
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_cpl) cc_desc_q <= desc_next;   // held through back-pressure
   end

   assign cc_tdata_o   = {{(`TX_DATA_W - 128){1'b0}}, cc_desc_q};
   assign cc_tkeep_o   = `TX_KEEP_W'(8'h0F);  // 3dw header + 1 data dword
   assign cc_tuser_o   = '0;
   assign cc_tlast_o   = cc_valid_q;          // single beat tlp
   assign cc_tvalid_o  = cc_valid_q;
   assign compl_done_o = compl_done_q;

   // beat stays on the bus until the core takes it
   a_cc_hold : assert property (@(posedge clk) disable iff (init_rst_i)
      cc_tvalid_o && !cc_tready_i |=> cc_tvalid_o && $stable(cc_tdata_o));

endmodule

//--- hdl/rq_write_requester.sv
/*
   requester memory write sequencer for the rq stream
   one header beat then len/8 payload beats carrying the payload counter
   starts on send_start_i or, on the echo side, once per stored echo trigger
*/
`timescale 1ns/10ps
`include "tx_engine_defs.svh"

module rq_write_requester
   import pcie_desc_pkg::*;
   import tx_ctrl_pkg::*;
(
   input  logic                  clk,
   input  logic                  init_rst_i,
   input  logic                  send_start_i,    // local start level
   input  logic                  echo_trigger_i,  // one pulse per received tlp
   input  logic                  echo_mode_i,
   input  logic [31:0]           target_addr_i,
   input  logic [31:0]           sender_addr_i,
   input  logic [9:0]            mwr_len_i,       // dword count in multiples of 8
   input  logic [3:0]            mwr_fbe_i,
   input  logic [3:0]            mwr_lbe_i,
   input  logic                  latency_reset_i,
   input  logic                  send_stop_i,     // log full so no new header
   input  logic                  rq_tready_i,
   output logic [`TX_DATA_W-1:0] rq_tdata_o,
   output logic [`TX_KEEP_W-1:0] rq_tkeep_o,
   output logic [`RQ_USER_W-1:0] rq_tuser_o,
   output logic                  rq_tlast_o,
   output logic                  rq_tvalid_o,
   output logic                  tlp_end_o
);

   rq_state_t              state_q;
   logic [`DW_CNT_W-1:0]   dw_left_q;     // dwords not yet issued
   logic [6:0]             tlp_cnt_q;     // upper tag bits
   logic [`ECHO_CNT_W-1:0] echo_cnt_q;    // echo triggers not yet answered
   logic [`DW_CNT_W-1:0]   pay_cnt_q;     // payload word, one per tlp
   logic [`TX_DATA_W-1:0]  tdata_q;
   logic                   tvalid_q;
   logic                   tlast_q;
   logic                   tlp_end_q;
   logic [3:0]             first_be_q;
   logic [3:0]             last_be_q;
   logic                   receiver_side;
   logic                   echo_ready;
   logic                   hdr_go;
   logic                   echo_hdr;
   logic                   echo_inc;
   logic                   last_beat;
   tag_t                   tag;
   rq_desc_t               hdr;

   // echo board sees its own target equal to the sender address
   assign receiver_side = (target_addr_i == sender_addr_i);
   assign echo_ready    = (|echo_cnt_q) && echo_mode_i && receiver_side;
   assign hdr_go        = (state_q == RQ_IDLE) && rq_tready_i && !send_stop_i
                          && (send_start_i || echo_ready);
   assign echo_hdr      = hdr_go && echo_ready;        // consumes one credit
   assign echo_inc      = echo_trigger_i && receiver_side;
   assign last_beat     = (state_q == RQ_PAYLOAD) && rq_tready_i
                          && (dw_left_q == `DW_CNT_W'(`TX_BEAT_DW));
   assign tag           = {tlp_cnt_q, !receiver_side}; // sides never share a tag

   always_comb begin
      hdr             = '0;
      hdr.tag         = tag;
      hdr.req_type    = `REQ_TYPE_MWR;
      hdr.dword_count = {1'b0, mwr_len_i};
      hdr.addr        = {32'd0, target_addr_i[31:2]};  // dword aligned
   end

   // --------------------
   // counters
   // --------------------
   always_ff @(posedge clk) begin
      if (init_rst_i || latency_reset_i) begin
         tlp_cnt_q  <= '0;
         echo_cnt_q <= '0;
         pay_cnt_q  <= '0;
      end else begin
         if (hdr_go) tlp_cnt_q <= tlp_cnt_q + 7'd1;   // wraps at 127
         if (last_beat) pay_cnt_q <= pay_cnt_q + 1'b1; // wraps at 1023
         case ({echo_inc, echo_hdr})
            2'b10:   echo_cnt_q <= echo_cnt_q + 1'b1;
            2'b01:   echo_cnt_q <= echo_cnt_q - 1'b1;
            default: echo_cnt_q <= echo_cnt_q;          // both or neither
         endcase
      end
   end

   // --------------------
   // sequencer
   // --------------------
   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         state_q   <= RQ_IDLE;
         dw_left_q <= '0;
         tvalid_q  <= 1'b0;
         tlast_q   <= 1'b0;
         tlp_end_q <= 1'b0;
      end else begin
         tlp_end_q <= last_beat;
         case (state_q)
            RQ_IDLE: begin
               if (hdr_go) begin
                  state_q   <= RQ_PAYLOAD;
                  dw_left_q <= mwr_len_i;
                  tvalid_q  <= 1'b1;
                  tlast_q   <= 1'b0;
               end else if (rq_tready_i) begin
                  tvalid_q  <= 1'b0;          // last beat gone so the bus is idle
                  tlast_q   <= 1'b0;
               end
            end
            RQ_PAYLOAD: begin
               if (rq_tready_i) begin
                  dw_left_q <= dw_left_q - `DW_CNT_W'(`TX_BEAT_DW);
                  tlast_q   <= last_beat;
                  if (last_beat) state_q <= RQ_IDLE;
               end
            end
            default: state_q <= RQ_IDLE;
         endcase
      end
   end

   // beat contents only change when a new beat is issued
   always_ff @(posedge clk) begin
      if (hdr_go) begin
         tdata_q    <= {{(`TX_DATA_W - 128){1'b0}}, hdr};
         first_be_q <= mwr_fbe_i;
         last_be_q  <= mwr_lbe_i;
      end else if (state_q == RQ_PAYLOAD && rq_tready_i) begin
         tdata_q    <= {{(`TX_DATA_W - `DW_CNT_W){1'b0}}, pay_cnt_q};
      end
   end

   assign rq_tdata_o  = tdata_q;
   assign rq_tkeep_o  = '1;                   // header and payload are full beats
   assign rq_tuser_o  = {{(`RQ_USER_W - 8){1'b0}}, last_be_q, first_be_q};
   assign rq_tlast_o  = tlast_q;
   assign rq_tvalid_o = tvalid_q;
   assign tlp_end_o   = tlp_end_q;

   // a beat stays on the bus unchanged until the core takes it
   a_rq_hold : assert property (@(posedge clk) disable iff (init_rst_i)
      rq_tvalid_o && !rq_tready_i |=> rq_tvalid_o && $stable(rq_tdata_o)
                                      && $stable(rq_tlast_o));
   a_rq_len : assert property (@(posedge clk) disable iff (init_rst_i)
      hdr_go |-> (mwr_len_i != '0) && (mwr_len_i[2:0] == 3'd0));

endmodule

//--- hdl/latency_logger.sv
/*
   timestamp counter and latency log writer
   one bram write per finished tlp; the log either wraps or,
   in one-shot mode, raises send_stop_o once the last entry is written
*/
`timescale 1ns/10ps
`include "tx_engine_defs.svh"

module latency_logger
   import tx_ctrl_pkg::*;
#(
   parameter int LOG_DEPTH = 16384   // entries, at most 16384
) (
   input  logic             clk,
   input  logic             init_rst_i,
   input  logic             send_start_i,
   input  logic             latency_reset_i,
   input  logic             tlp_end_i,        // last payload beat issued
   input  logic             log_continue_i,   // 1 wrap, 0 stop when full
   output logic [`TS_W-1:0] latency_count_o,  // also the bram write data
   output logic             log_wr_en_o,
   output log_addr_t        log_addr_o,
   output logic             send_stop_o
);

   localparam log_addr_t LOG_LAST = log_addr_t'(LOG_DEPTH - 1);

   // timestamp, counts while sending is enabled
   always_ff @(posedge clk) begin
      if (init_rst_i || latency_reset_i) begin
         latency_count_o <= '0;
      end else if (send_start_i) begin
         latency_count_o <= latency_count_o + 1'b1;
      end
   end

   // --------------------
   // log address and stop
   // --------------------
   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         log_wr_en_o <= 1'b0;
         log_addr_o  <= '0;
         send_stop_o <= 1'b0;
      end else begin
         log_wr_en_o <= tlp_end_i && !send_stop_o;   // no writes past a full log
         if (latency_reset_i) begin
            log_addr_o  <= '0;
            send_stop_o <= 1'b0;
         end else if (log_wr_en_o) begin
            if (log_addr_o != LOG_LAST) begin
               log_addr_o <= log_addr_o + 1'b1;      // advance after the write
            end else if (log_continue_i) begin
               log_addr_o <= '0;                     // wrap
            end else begin
               send_stop_o <= 1'b1;                  // full, address stays
            end
         end
      end
   end

   // relies on tlp_end pulses being at least two cycles apart
   a_no_wr_stop : assert property (@(posedge clk) disable iff (init_rst_i)
      send_stop_o |-> !log_wr_en_o);

endmodule

//--- hdl/tx_engine_top.sv
/*
   transmit side of the pcie test engine
   completer completions on cc, memory write tlps on rq,
   and the latency timestamp with its log bram write port
*/
`timescale 1ns/10ps
`include "tx_engine_defs.svh"

module tx_engine_top
   import tx_ctrl_pkg::*;
#(
   parameter int LOG_DEPTH = 16384
) (
   input  logic                  clk,
   input  logic                  init_rst_i,
   // cc stream
   output logic [`TX_DATA_W-1:0] cc_tdata_o,
   output logic [`TX_KEEP_W-1:0] cc_tkeep_o,
   output logic                  cc_tlast_o,
   output logic [`CC_USER_W-1:0] cc_tuser_o,
   output logic                  cc_tvalid_o,
   input  logic                  cc_tready_i,
   // rq stream
   output logic [`TX_DATA_W-1:0] rq_tdata_o,
   output logic [`TX_KEEP_W-1:0] rq_tkeep_o,
   output logic                  rq_tlast_o,
   output logic [`RQ_USER_W-1:0] rq_tuser_o,
   output logic                  rq_tvalid_o,
   input  logic                  rq_tready_i,
   // completion request from rx
   input  logic                  req_compl_i,
   input  logic [2:0]            req_tc_i,
   input  logic [1:0]            req_attr_i,
   input  logic [9:0]            req_len_i,
   input  logic [15:0]           req_rid_i,
   input  logic [7:0]            req_tag_i,
   input  logic [3:0]            req_be_i,
   input  logic [6:0]            req_addr_i,
   input  logic [31:0]           rd_data_i,
   output logic                  compl_done_o,
   // write settings
   input  logic                  send_start_i,
   input  logic                  echo_trigger_i,
   input  logic                  echo_mode_i,
   input  logic [31:0]           target_addr_i,
   input  logic [31:0]           sender_addr_i,
   input  logic [9:0]            mwr_len_i,
   input  logic [3:0]            mwr_fbe_i,
   input  logic [3:0]            mwr_lbe_i,
   // latency and log bram
   input  logic                  latency_reset_i,
   input  logic                  log_continue_i,
   output logic [`TS_W-1:0]      latency_count_o,
   output logic                  log_wr_en_o,
   output log_addr_t             log_addr_o,
   output logic                  send_stop_o
);

   logic tlp_end;   // requester to logger

   cc_completer i_cc_completer (.*);

   rq_write_requester i_rq_write_requester (
      .*,
      .send_stop_i (send_stop_o),
      .tlp_end_o   (tlp_end)
   );

   latency_logger #(
      .LOG_DEPTH (LOG_DEPTH)
   ) i_latency_logger (
      .*,
      .tlp_end_i (tlp_end)
   );

endmodule

//--- sim/tb_tx_engine.sv
/*
   self-checking testbench for the pcie tx engine
   reads one test per line from sim/tx_engine_cases.txt and runs it against
   the completer, the write requester, the echo path, the log and the timestamp
*/
`timescale 1ns/10ps
`include "tx_engine_defs.svh"

module tb_tx_engine
   import tx_ctrl_pkg::*;
();

   localparam int LOG_DEPTH = 4;    // small log so it fills quickly
   localparam int MAX_CASES = 64;
   localparam int QUIET_CYC = 20;   // idle cycles that close a tlp run

   logic                  clk;
   logic                  init_rst_i;
   logic [`TX_DATA_W-1:0] cc_tdata_o;
   logic [`TX_KEEP_W-1:0] cc_tkeep_o;
   logic                  cc_tlast_o;
   logic [`CC_USER_W-1:0] cc_tuser_o;
   logic                  cc_tvalid_o;
   logic                  cc_tready_i;
   logic [`TX_DATA_W-1:0] rq_tdata_o;
   logic [`TX_KEEP_W-1:0] rq_tkeep_o;
   logic                  rq_tlast_o;
   logic [`RQ_USER_W-1:0] rq_tuser_o;
   logic                  rq_tvalid_o;
   logic                  rq_tready_i;
   logic                  req_compl_i;
   logic [2:0]            req_tc_i;
   logic [1:0]            req_attr_i;
   logic [9:0]            req_len_i;
   logic [15:0]           req_rid_i;
   logic [7:0]            req_tag_i;
   logic [3:0]            req_be_i;
   logic [6:0]            req_addr_i;
   logic [31:0]           rd_data_i;
   logic                  compl_done_o;
   logic                  send_start_i;
   logic                  echo_trigger_i;
   logic                  echo_mode_i;
   logic [31:0]           target_addr_i;
   logic [31:0]           sender_addr_i;
   logic [9:0]            mwr_len_i;
   logic [3:0]            mwr_fbe_i;
   logic [3:0]            mwr_lbe_i;
   logic                  latency_reset_i;
   logic                  log_continue_i;
   logic [`TS_W-1:0]      latency_count_o;
   logic                  log_wr_en_o;
   log_addr_t             log_addr_o;
   logic                  send_stop_o;

   // case table of fields p0..p8 then e0 e1
   string       kind_a [0:MAX_CASES-1];
   string       name_a [0:MAX_CASES-1];
   logic [31:0] fld    [0:MAX_CASES-1][0:10];
   int          n_cases = 0;
   logic        cases_loaded = 1'b0;   // starts the watchdog

   string       cur_test;
   int          test_err;
   int          err_total = 0;
   int          n_failed = 0;
   logic [31:0] lfsr_q;
   int          wr_cnt;         // log writes since the last latency reset
   log_addr_t   last_addr;

   tx_engine_top #(
      .LOG_DEPTH (LOG_DEPTH)
   ) i_tx_engine_top (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns
   end

   // --------------------
   // helpers
   // --------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic rand_bit();
      lfsr_q = lfsr_step(lfsr_q);   // one step per bit
      return lfsr_q[0];
   endfunction

   task automatic check(input string what, input logic [255:0] exp,
                        input logic [255:0] act);
      if (exp !== act) begin
         $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, exp, act);
         test_err++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%s: %s", cur_test, msg);
      test_err++;
   endtask

   // completion beat as laid out per dword
   function automatic logic [255:0] cpl_expect(input logic [12:0] bc,
                                               input logic [6:0] la);
      logic [31:0] dw0;
      logic [31:0] dw1;
      logic [31:0] dw2;
      dw0 = {3'b0, bc, 9'b0, la};                        // addr type 0
      dw1 = {req_rid_i, 5'b0, 1'b0, req_len_i};          // status successful
      dw2 = {2'b0, req_attr_i, req_tc_i, 17'b0, req_tag_i};  // completer id 0
      return {128'b0, rd_data_i, dw2, dw1, dw0};
   endfunction

   // write header with the tag built from tlp index and side bit
   function automatic logic [255:0] hdr_expect(input int k, input logic side);
      logic [31:0] dw2;
      logic [31:0] dw3;
      dw2 = {16'h0, 1'b0, 4'h1, 1'b0, mwr_len_i};        // type memory write
      dw3 = {24'h0, k[6:0], side};
      return {128'b0, dw3, dw2, 32'h0, target_addr_i[31:2], 2'b00};
   endfunction

   task automatic clear_state();
      @(negedge clk);
      send_start_i    = 1'b0;
      echo_trigger_i  = 1'b0;
      rq_tready_i     = 1'b0;
      cc_tready_i     = 1'b0;
      req_compl_i     = 1'b0;
      latency_reset_i = 1'b1;   // clears counters, log address and stop
      @(negedge clk);
      latency_reset_i = 1'b0;
      wr_cnt          = 0;
      last_addr       = '0;
   endtask

   // --------------------
   // rq stream monitor
   // --------------------
   // holds start until n_req headers went out and expects n_exp tlps in all
   task automatic tlp_run(input int n_req, input int n_exp, input bit stall,
                          input logic side);
      int hdrs;
      int beat;        // 0 header then payload beats
      int beats_exp;
      int quiet;
      int cycles;
      hdrs      = 0;
      beat      = 0;
      quiet     = 0;
      cycles    = 0;
      beats_exp = mwr_len_i >> 3;
      send_start_i = (n_req > 0);
      while (quiet < QUIET_CYC && cycles < 150) begin
         @(negedge clk);
         cycles++;
         if (log_wr_en_o) begin
            check("log address", log_continue_i ? wr_cnt % LOG_DEPTH : wr_cnt,
                  log_addr_o);
            last_addr = log_addr_o;
            wr_cnt++;
         end
         rq_tready_i = stall ? rand_bit() : 1'b1;
         if (rq_tvalid_o && rq_tready_i) begin   // taken on the next edge
            check("rq tkeep", 8'hff, rq_tkeep_o);
            if (beat == 0) begin
               check("rq header", hdr_expect(hdrs, side), rq_tdata_o);
               check("rq tuser", {mwr_lbe_i, mwr_fbe_i}, rq_tuser_o);
               check("header tlast", 1'b0, rq_tlast_o);
               hdrs++;
               if (hdrs >= n_req) send_start_i = 1'b0;
            end else begin
               check("payload word", hdrs - 1, rq_tdata_o);
               check("payload tlast", beat == beats_exp, rq_tlast_o);
            end
            beat = (beat == beats_exp) ? 0 : beat + 1;
         end
         if (hdrs >= n_exp && beat == 0) quiet++;
         else quiet = 0;
      end
      if (quiet < QUIET_CYC) note_failure("timed out waiting for the write TLPs");
      check("tlp count", n_exp, hdrs);
      send_start_i = 1'b0;
      rq_tready_i  = 1'b0;
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic cpl_test(input int c);
      int   beats;
      int   dones;
      int   tail;
      int   n;
      logic [255:0] exp;
      req_be_i    = fld[c][0][3:0];
      req_addr_i  = fld[c][1][6:0];
      req_tag_i   = fld[c][2][7:0];
      req_rid_i   = fld[c][3][15:0];
      req_len_i   = fld[c][4][9:0];
      rd_data_i   = fld[c][5];
      req_tc_i    = fld[c][6][2:0];
      req_attr_i  = fld[c][7][1:0];
      cc_tready_i = 1'b0;
      req_compl_i = 1'b1;
      exp   = cpl_expect(fld[c][9][12:0], fld[c][10][6:0]);
      beats = 0;
      dones = 0;
      tail  = 0;
      n     = 0;
      @(negedge clk);
      check("cc valid one cycle after request", 1'b0, cc_tvalid_o);
      @(negedge clk);
      check("cc valid two cycles after request", 1'b1, cc_tvalid_o);
      req_compl_i = 1'b0;   // level drops once the beat is up
      while (tail < 4 && n < 60) begin
         if (cc_tvalid_o) begin
            check("cc tdata", exp, cc_tdata_o);   // held under stalls
            check("cc tlast", 1'b1, cc_tlast_o);
            check("cc tkeep", 8'h0f, cc_tkeep_o);
            check("cc tuser", 0, cc_tuser_o);
         end
         dones += compl_done_o;
         cc_tready_i = fld[c][8][0] ? rand_bit() : 1'b1;
         if (cc_tvalid_o && cc_tready_i) beats++;
         if (beats > 0) tail++;
         @(negedge clk);
         n++;
      end
      if (beats == 0) note_failure("no completion beat was taken before the timeout");
      check("cc beats", 1, beats);
      check("compl_done cycles", 1, dones);
      cc_tready_i = 1'b0;
   endtask

   task automatic mwr_test(input int c);
      mwr_len_i     = fld[c][0][9:0];
      mwr_fbe_i     = fld[c][1][3:0];
      mwr_lbe_i     = fld[c][2][3:0];
      target_addr_i = fld[c][3];
      sender_addr_i = ~fld[c][3];   // not the echo board
      echo_mode_i   = 1'b0;
      tlp_run(fld[c][5], fld[c][9], fld[c][4][0], fld[c][10][0]);
   endtask

   task automatic echo_test(input int c);
      target_addr_i = fld[c][2];
      sender_addr_i = fld[c][2];    // receiver side
      echo_mode_i   = fld[c][1][0];
      mwr_len_i     = fld[c][3][9:0];
      mwr_fbe_i     = 4'hf;
      mwr_lbe_i     = 4'hf;
      rq_tready_i   = 1'b0;         // credits pile up first
      repeat (fld[c][0]) begin
         @(negedge clk);
         echo_trigger_i = 1'b1;
         @(negedge clk);
         echo_trigger_i = 1'b0;
      end
      tlp_run(0, fld[c][9], fld[c][4][0], fld[c][10][0]);
      echo_mode_i = 1'b0;
   endtask

   task automatic log_test(input int c);
      log_continue_i = fld[c][0][0];
      mwr_len_i      = fld[c][2][9:0];
      mwr_fbe_i      = 4'hf;
      mwr_lbe_i      = 4'hf;
      target_addr_i  = 32'h9000_0000;
      sender_addr_i  = 32'h0;
      tlp_run(fld[c][1], fld[c][1], fld[c][3][0], 1'b1);
      check("log writes", fld[c][1], wr_cnt);
      check("last log address", fld[c][9], last_addr);
      check("send_stop", fld[c][10][0], send_stop_o);
      if (send_stop_o) begin
         tlp_run(1, 0, fld[c][3][0], 1'b1);   // start held on a full log
         clear_state();
         check("send_stop after latency reset", 1'b0, send_stop_o);
      end
   endtask

   task automatic ts_test(input int c);
      rq_tready_i = 1'b0;   // no header while counting
      check("timestamp after reset", 0, latency_count_o);
      send_start_i = 1'b1;
      repeat (fld[c][0]) @(negedge clk);
      send_start_i = 1'b0;
      @(negedge clk);
      check("timestamp", fld[c][9], latency_count_o);
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin : main_seq
      int    fd;
      int    rc;
      string line;
      init_rst_i      = 1'b1;
      cc_tready_i     = 1'b0;
      rq_tready_i     = 1'b0;
      req_compl_i     = 1'b0;
      req_tc_i        = '0;
      req_attr_i      = '0;
      req_len_i       = '0;
      req_rid_i       = '0;
      req_tag_i       = '0;
      req_be_i        = '0;
      req_addr_i      = '0;
      rd_data_i       = '0;
      send_start_i    = 1'b0;
      echo_trigger_i  = 1'b0;
      echo_mode_i     = 1'b0;
      target_addr_i   = '0;
      sender_addr_i   = 32'h1;
      mwr_len_i       = 10'd8;
      mwr_fbe_i       = 4'hf;
      mwr_lbe_i       = 4'hf;
      latency_reset_i = 1'b0;
      log_continue_i  = 1'b0;
      lfsr_q          = 32'hade2_a066;
      wr_cnt          = 0;
      last_addr       = '0;

      fd = $fopen("sim/tx_engine_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file sim/tx_engine_cases.txt");
         err_total++;
      end else begin
         while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin   // skip notes
               rc = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h",
                            kind_a[n_cases], name_a[n_cases],
                            fld[n_cases][0], fld[n_cases][1], fld[n_cases][2],
                            fld[n_cases][3], fld[n_cases][4], fld[n_cases][5],
                            fld[n_cases][6], fld[n_cases][7], fld[n_cases][8],
                            fld[n_cases][9], fld[n_cases][10]);
               if (rc == 13) begin
                  n_cases++;
               end else begin
                  $display("case line has wrong field count: %s", line);
                  err_total++;
               end
            end
         end
         $fclose(fd);
      end
      cases_loaded = 1'b1;

      repeat (4) @(negedge clk);   // reset over 4 rising edges
      init_rst_i = 1'b0;

      for (int i = 0; i < n_cases; i++) begin
         cur_test = name_a[i];
         test_err = 0;
         clear_state();
         case (kind_a[i])
            "cpl":   cpl_test(i);
            "mwr":   mwr_test(i);
            "echo":  echo_test(i);
            "log":   log_test(i);
            "ts":    ts_test(i);
            default: note_failure("unknown test kind in the case file");
         endcase
         $display("test %0d %s: %s", i, cur_test, (test_err == 0) ? "ok" : "mismatch");
         if (test_err != 0) n_failed++;
         err_total += test_err;
      end

      $display("tests %0d, failed %0d, errors %0d", n_cases, n_failed, err_total);
      if (err_total == 0 && n_cases > 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // 200 cycles per test
   initial begin : watchdog
      wait (cases_loaded);
      repeat (n_cases * 200) @(posedge clk);
      $display("watchdog expired, the tests did not finish in %0d cycles", n_cases * 200);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- sim/tx_engine_cases.txt
# one test per line: kind name p0..p8 (stimulus) e0 e1 (expected), numbers in hex
# cpl:  be addr tag rid len data tc attr stall | byte_count lower_addr
# mwr:  len fbe lbe target stall tlps 0 0 0 | tlps tag_lsb
# echo: triggers mode target len stall 0 0 0 0 | tlps tag_lsb
# log:  continue tlps len stall 0 0 0 0 0 | last_addr send_stop
# ts:   start_cycles 0 0 0 0 0 0 0 0 | count 0
cpl  cpl_be_f     f 10 a5 1234 1 deadbeef 5 2 0 4 40
cpl  cpl_be_6     6 23 01 beef 1 01234567 0 1 0 2 0d
cpl  cpl_be_4     4 05 7e 0001 1 89abcdef 7 3 0 1 16
cpl  cpl_be_0     0 7f 3c 8000 1 00000000 2 0 0 1 7c
cpl  cpl_be_7     7 08 10 4242 1 cafef00d 1 0 1 3 20
cpl  cpl_be_e     e 01 ff 00ff 1 5a5a5a5a 3 1 1 3 05
cpl  cpl_be_8     8 02 42 a0a0 1 11111111 4 2 1 1 0b
cpl  cpl_be_9     9 1c 77 0f0f 1 ffffffff 6 3 1 4 70
cpl  cpl_be_c     c 00 08 1357 1 24681357 0 0 1 2 02
mwr  mwr_len8     8 f f 80001000 0 1 0 0 0 1 1
mwr  mwr_len24    18 3 c 4000a00e 1 3 0 0 0 3 1
echo echo_rx      3 1 20000000 10 1 0 0 0 0 3 0
echo echo_off     2 0 20000000 8 0 0 0 0 0 0 0
log  log_oneshot  0 4 8 1 0 0 0 0 0 3 1
log  log_wrap     1 5 8 0 0 0 0 0 0 0 0
ts   ts_count     19 0 0 0 0 0 0 0 0 19 0

//--- flist.f
+incdir+hdl
hdl/pcie_desc_pkg.sv
hdl/tx_ctrl_pkg.sv
hdl/cc_completer.sv
hdl/rq_write_requester.sv
hdl/latency_logger.sv
hdl/tx_engine_top.sv
sim/tb_tx_engine.sv

//--- Bender.yml
package:
  name: tx_engine

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pcie_desc_pkg.sv
      - hdl/tx_ctrl_pkg.sv
      - hdl/cc_completer.sv
      - hdl/rq_write_requester.sv
      - hdl/latency_logger.sv
      - hdl/tx_engine_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_tx_engine.sv
